// ==== design/s2mm_burst_ctrl.sv ====
//****************************************
// burst controller FSM
// AXI write address, data and response
// progress counters and interrupts
//****************************************
`timescale 1ns/1ps
`default_nettype none

module s2mm_burst_ctrl (
	input  logic                clk,
	input  logic                rst_n,

	input  s2mm_pkg::dma_cfg_t  cfg,
	output s2mm_pkg::dma_stat_t stat,

	input  s2mm_pkg::stream_t   head,
	input  s2mm_pkg::occ_t      occupancy,
	output logic                pop,

	output s2mm_pkg::axi_aw_t   aw,
	output logic                awvalid,
	input  logic                awready,

	output s2mm_pkg::axi_w_t    w,
	output logic                wvalid,
	input  logic                wready,

	input  s2mm_pkg::axi_b_t    b,
	input  logic                bvalid,
	output logic                bready
);

	typedef enum logic [1:0] {
		st_idle,
		st_addr,
		st_data,
		st_resp
	} state_t;

	state_t state;

	s2mm_pkg::len_t beat_cnt;
	s2mm_pkg::irq_t irq;
	logic [2:0]     status_flags;
	logic [31:0]    bytes_written;
	logic [31:0]    last_msg_end;
	logic [31:0]    msg_end_b;    // message end seen in the current burst
	logic           msg_seen;
	logic [31:0]    size_q;       // buffer size latched at run start
	logic           flush_done;

	logic [31:0]    burst_nbytes;
	logic [31:0]    bytes_next;
	logic [31:0]    beat_end;
	logic           run_over;

	assign burst_nbytes = (32'(aw.len) + 32'd1) * s2mm_pkg::beat_bytes;
	assign bytes_next   = bytes_written + burst_nbytes;
	assign beat_end     = bytes_written + (32'(beat_cnt) + 32'd1) * s2mm_pkg::beat_bytes;

	// stop after this burst: buffer full, enable dropped, or flush drained
	assign run_over = (size_q - bytes_next < s2mm_pkg::burst_bytes)
		|| !cfg.enable
		|| (cfg.flush && occupancy == '0);

	//****************************************
	// write data channel
	//****************************************
	assign wvalid = (state == st_data) && (occupancy != '0);
	assign w.data = head.data;
	assign w.last = (beat_cnt == aw.len);
	assign pop    = wvalid & wready;

	assign stat.irq           = irq;
	assign stat.status_flags  = status_flags;
	assign stat.bytes_written = bytes_written;
	assign stat.last_msg_end  = last_msg_end;
	assign stat.flush_done    = flush_done;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state         <= st_idle;
			aw            <= '0;
			awvalid       <= 1'b0;
			bready        <= 1'b0;
			beat_cnt      <= '0;
			irq           <= '0;
			status_flags  <= '0;
			bytes_written <= '0;
			last_msg_end  <= '0;
			msg_end_b     <= '0;
			msg_seen      <= 1'b0;
			size_q        <= '0;
			flush_done    <= 1'b0;
		end else begin
			irq        <= irq & ~cfg.clear_irq & cfg.irq_en; // bits set below win
			flush_done <= 1'b0;

			case (state)
				st_idle: begin
					if (cfg.enable && irq == '0 && cfg.mem_size >= s2mm_pkg::burst_bytes) begin
						state         <= st_addr;
						size_q        <= cfg.mem_size;
						bytes_written <= '0;
						last_msg_end  <= '0;
						status_flags  <= 3'b001; // busy, errors cleared
						aw.addr       <= cfg.mem_base;
					end
				end

				st_addr: begin
					if (!awvalid) begin
						if (!cfg.enable) begin
							state           <= st_idle;
							status_flags[0] <= 1'b0;
						end else if (occupancy >= s2mm_pkg::occ_t'(s2mm_pkg::max_burst)) begin
							aw.len  <= s2mm_pkg::len_t'(s2mm_pkg::max_burst - 1);
							awvalid <= 1'b1;
						end else if (cfg.flush && occupancy != '0) begin
							aw.len  <= s2mm_pkg::len_t'(occupancy - 5'd1); // short flush burst
							awvalid <= 1'b1;
						end
					end else if (awready) begin
						awvalid  <= 1'b0;
						msg_seen <= 1'b0;
						state    <= st_data;
					end
				end

				st_data: begin
					if (pop) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (head.last) begin
							msg_seen  <= 1'b1;
							msg_end_b <= beat_end;
						end
						if (w.last) begin
							beat_cnt <= '0;
							bready   <= 1'b1;
							state    <= st_resp;
						end
					end
				end

				st_resp: begin
					if (bvalid && bready) begin
						bready <= 1'b0;
						if (!b.resp[1]) begin
							// OKAY or EXOKAY
							bytes_written <= bytes_next;
							aw.addr       <= aw.addr + burst_nbytes;
							if (msg_seen) begin
								last_msg_end <= msg_end_b;
								irq[1]       <= cfg.irq_en[1];
							end
							if (run_over) begin
								state           <= st_idle;
								status_flags[0] <= 1'b0;
								irq[0]          <= cfg.irq_en[0];
								flush_done      <= cfg.flush;
							end else begin
								state <= st_addr;
							end
						end else begin
							state        <= st_idle;
							status_flags <= {b.resp[0], ~b.resp[0], 1'b0}; // decerr, slverr
							irq[2]       <= cfg.irq_en[2];
						end
					end
				end

				default: state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/s2mm_fifo.sv ====
//****************************************
// stream FIFO, 16 entries
// data plus last flag, occupancy output
//****************************************
`timescale 1ns/1ps
`default_nettype none

module s2mm_fifo (
	input  logic              clk,
	input  logic              rst_n,

	input  s2mm_pkg::stream_t in_beat,
	input  logic              in_valid,
	output logic              in_ready,

	output s2mm_pkg::stream_t head,
	input  logic              pop,
	output s2mm_pkg::occ_t    occupancy
);

	s2mm_pkg::stream_t mem [s2mm_pkg::fifo_depth];

	logic [$clog2(s2mm_pkg::fifo_depth)-1:0] wr_ptr;
	logic [$clog2(s2mm_pkg::fifo_depth)-1:0] rd_ptr;
	s2mm_pkg::occ_t count;

	logic push_ok;
	logic pop_ok;

	assign in_ready  = (count != s2mm_pkg::occ_t'(s2mm_pkg::fifo_depth));
	assign push_ok   = in_valid & in_ready;
	assign pop_ok    = pop & (count != '0); // never pop an empty FIFO
	assign head      = mem[rd_ptr];         // fall-through head
	assign occupancy = count;

	// storage
	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_ptr] <= in_beat;
		end
	end

	//****************************************
	// pointers and count
	//****************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/s2mm_pkg.sv ====
//****************************************
// shared widths, sizes and vector types
// channel payload structs for stream and AXI
// configuration and status structs
//****************************************
`default_nettype none

package s2mm_pkg;

	localparam int addr_w      = 32;
	localparam int data_w      = 64;
	localparam int max_burst   = 16;
	localparam int beat_bytes  = 8;
	localparam int burst_bytes = max_burst * beat_bytes; // 128
	localparam int fifo_depth  = 16;

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [data_w-1:0] data_t;
	typedef logic [4:0]        occ_t;  // 0 .. fifo_depth
	typedef logic [7:0]        len_t;  // beats minus one
	typedef logic [2:0]        irq_t;  // done, message, error

	typedef struct packed {
		data_t data;
		logic  last;
	} stream_t;

	typedef struct packed {
		addr_t addr;
		len_t  len;
	} axi_aw_t;

	typedef struct packed {
		data_t data;
		logic  last;
	} axi_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axi_b_t;

	//****************************************
	// register block <-> burst controller
	//****************************************
	typedef struct packed {
		logic        enable;
		logic        flush;
		irq_t        irq_en;
		irq_t        clear_irq; // one-cycle pulse
		addr_t       mem_base;
		logic [31:0] mem_size;
	} dma_cfg_t;

	typedef struct packed {
		irq_t        irq;
		logic [2:0]  status_flags; // busy, slave error, decode error
		logic [31:0] bytes_written;
		logic [31:0] last_msg_end;
		logic        flush_done;   // pulse
	} dma_stat_t;

endpackage

`default_nettype wire

// ==== design/s2mm_regs.sv ====
//****************************************
// APB register block
// holds configuration, returns live status
//****************************************
`timescale 1ns/1ps
`default_nettype none

module s2mm_regs (
	input  logic                clk,
	input  logic                rst_n,

	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [7:0]          paddr,
	input  logic [31:0]         pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr,

	input  s2mm_pkg::dma_stat_t stat,
	output s2mm_pkg::dma_cfg_t  cfg
);

	logic addr_ok;
	logic wr_en;

	assign wr_en   = psel & penable & pwrite & addr_ok;
	assign pready  = 1'b1; // no wait states
	assign pslverr = psel & penable & ~addr_ok;

	//****************************************
	// read mux
	//****************************************
	always_comb begin
		addr_ok = 1'b1;
		prdata  = '0;
		case (paddr)
			8'h00: prdata = {25'd0, cfg.irq_en, 2'b00, cfg.flush, cfg.enable};
			8'h04: prdata = {29'd0, stat.status_flags};
			8'h08: prdata = {29'd0, stat.irq};
			8'h0c: prdata = cfg.mem_base;
			8'h10: prdata = cfg.mem_size;
			8'h14: prdata = stat.bytes_written;
			8'h18: prdata = stat.last_msg_end;
			default: addr_ok = 1'b0;
		endcase
	end

	//****************************************
	// write side
	//****************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg <= '0;
		end else begin
			cfg.clear_irq <= '0; // pulse only

			if (stat.flush_done) begin
				cfg.flush <= 1'b0;
			end

			if (wr_en) begin
				case (paddr)
					8'h00: begin
						cfg.enable <= pwdata[0];
						cfg.flush  <= pwdata[1];
						cfg.irq_en <= pwdata[6:4];
					end
					8'h08: cfg.clear_irq <= pwdata[2:0]; // write one to clear
					8'h0c: cfg.mem_base  <= pwdata;
					8'h10: cfg.mem_size  <= pwdata;
					default: ; // read-only registers ignore writes
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/s2mm_top.sv ====
//****************************************
// stream to memory DMA top level
//****************************************
`timescale 1ns/1ps
`default_nettype none

module s2mm_top (
	input  logic                  clk,
	input  logic                  rst_n,

	// APB
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [7:0]            paddr,
	input  logic [31:0]           pwdata,
	output logic [31:0]           prdata,
	output logic                  pready,
	output logic                  pslverr,

	// stream in
	input  s2mm_pkg::data_t       s_axis_tdata,
	input  logic                  s_axis_tlast,
	input  logic                  s_axis_tvalid,
	output logic                  s_axis_tready,

	// AXI write
	output s2mm_pkg::addr_t       m_axi_awaddr,
	output s2mm_pkg::len_t        m_axi_awlen,
	output logic                  m_axi_awvalid,
	input  logic                  m_axi_awready,
	output s2mm_pkg::data_t       m_axi_wdata,
	output logic                  m_axi_wlast,
	output logic                  m_axi_wvalid,
	input  logic                  m_axi_wready,
	input  logic [1:0]            m_axi_bresp,
	input  logic                  m_axi_bvalid,
	output logic                  m_axi_bready,

	output s2mm_pkg::irq_t        irq
);

	s2mm_pkg::dma_cfg_t  cfg;
	s2mm_pkg::dma_stat_t stat;
	s2mm_pkg::stream_t   s_beat;
	s2mm_pkg::stream_t   head;
	s2mm_pkg::occ_t      occupancy;
	s2mm_pkg::axi_aw_t   aw;
	s2mm_pkg::axi_w_t    w;
	s2mm_pkg::axi_b_t    b;
	logic                pop;

	assign s_beat.data  = s_axis_tdata;
	assign s_beat.last  = s_axis_tlast;
	assign m_axi_awaddr = aw.addr;
	assign m_axi_awlen  = aw.len;
	assign m_axi_wdata  = w.data;
	assign m_axi_wlast  = w.last;
	assign b.resp       = m_axi_bresp;
	assign irq          = stat.irq;

	s2mm_regs u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.stat    (stat),
		.cfg     (cfg)
	);

	s2mm_fifo u_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_beat   (s_beat),
		.in_valid  (s_axis_tvalid),
		.in_ready  (s_axis_tready),
		.head      (head),
		.pop       (pop),
		.occupancy (occupancy)
	);

	s2mm_burst_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.stat      (stat),
		.head      (head),
		.occupancy (occupancy),
		.pop       (pop),
		.aw        (aw),
		.awvalid   (m_axi_awvalid),
		.awready   (m_axi_awready),
		.w         (w),
		.wvalid    (m_axi_wvalid),
		.wready    (m_axi_wready),
		.b         (b),
		.bvalid    (m_axi_bvalid),
		.bready    (m_axi_bready)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the stream to memory DMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_s2mm -f sim.f -o sim_s2mm
out=$(./obj_dir/sim_s2mm)
echo "$out"

if echo "$out" | grep -q "^PASS: all tests$"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== sim.f ====
design/s2mm_pkg.sv
design/s2mm_regs.sv
design/s2mm_fifo.sv
design/s2mm_burst_ctrl.sv
design/s2mm_top.sv
tb/tb_axi_mem.sv
tb/tb_s2mm.sv

// ==== tb/tb_axi_mem.sv ====
//****************************************
// AXI write slave memory model
// random ready stalls, injectable error address
//****************************************
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem (
	input  logic            clk,
	input  logic            rst_n,
	input  logic [1:0]      stall,         // bit 0 holds awready low, bit 1 wready
	input  logic            err_en,
	input  s2mm_pkg::addr_t err_addr,

	input  s2mm_pkg::addr_t m_axi_awaddr,
	input  s2mm_pkg::len_t  m_axi_awlen,
	input  logic            m_axi_awvalid,
	output logic            m_axi_awready,
	input  s2mm_pkg::data_t m_axi_wdata,
	input  logic            m_axi_wlast,
	input  logic            m_axi_wvalid,
	output logic            m_axi_wready,
	output logic [1:0]      m_axi_bresp,
	output logic            m_axi_bvalid,
	input  logic            m_axi_bready
);

	s2mm_pkg::data_t mem [1024]; // 8 KB, indexed by address bits 12:3

	s2mm_pkg::addr_t wr_addr;
	s2mm_pkg::len_t  len_q;
	s2mm_pkg::len_t  last_len;   // awlen of the most recent burst
	s2mm_pkg::len_t  beat;
	logic            busy;
	logic            in_data;
	logic            err_hit;
	int              bursts;     // completed B handshakes
	int              proto_errs;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m_axi_awready <= 1'b0;
			m_axi_wready  <= 1'b0;
			m_axi_bvalid  <= 1'b0;
			m_axi_bresp   <= 2'b00;
			wr_addr       <= '0;
			len_q         <= '0;
			last_len      <= '0;
			beat          <= '0;
			busy          <= 1'b0;
			in_data       <= 1'b0;
			err_hit       <= 1'b0;
			bursts        <= 0;
			proto_errs    <= 0;
		end else begin
			if (m_axi_awvalid && m_axi_awready) begin
				m_axi_awready <= 1'b0;
				busy          <= 1'b1;
				in_data       <= 1'b1;
				wr_addr       <= m_axi_awaddr;
				len_q         <= m_axi_awlen;
				last_len      <= m_axi_awlen;
				beat          <= '0;
				err_hit       <= err_en && (m_axi_awaddr == err_addr);
			end else if (m_axi_awvalid && !busy && !stall[0]) begin
				m_axi_awready <= 1'b1;
			end

			if (in_data) begin
				m_axi_wready <= ~stall[1];
			end

			if (m_axi_wvalid && m_axi_wready) begin
				if (!err_hit) begin
					mem[wr_addr[12:3]] <= m_axi_wdata; // error bursts leave memory alone
				end
				wr_addr <= wr_addr + 32'd8;
				beat    <= beat + 8'd1;
				if (m_axi_wlast != (beat == len_q)) begin
					proto_errs <= proto_errs + 1;
					$display("memory model: wlast mismatch at beat %0d, awlen %0d", beat, len_q);
				end
				if (m_axi_wlast) begin
					in_data      <= 1'b0;
					m_axi_wready <= 1'b0;
					m_axi_bvalid <= 1'b1;
					m_axi_bresp  <= err_hit ? 2'b10 : 2'b00; // SLVERR or OKAY
				end
			end

			if (m_axi_bvalid && m_axi_bready) begin
				m_axi_bvalid <= 1'b0;
				busy         <= 1'b0;
				bursts       <= bursts + 1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_s2mm.sv ====
//****************************************
// testbench top for the stream to memory DMA
// APB and stream drivers, reference model
// checks, watchdog and summary
//****************************************
`timescale 1ns/1ps
`default_nettype none

module tb_s2mm;

	localparam logic [31:0] seed            = 32'hb28d_6bbb;
	localparam int          num_tests       = 6;
	localparam int          cycles_per_test = 4000;

	typedef struct packed {
		logic [31:0] bytes;
		logic [31:0] msg_end;
		logic [2:0]  irq;
		logic [2:0]  flags;
		logic [15:0] mem_beats; // beats committed to memory
	} expect_t;

	logic            clk;
	logic            rst_n;
	logic            psel;
	logic            penable;
	logic            pwrite;
	logic [7:0]      paddr;
	logic [31:0]     pwdata;
	logic [31:0]     prdata;
	logic            pready;
	logic            pslverr;
	s2mm_pkg::data_t s_axis_tdata;
	logic            s_axis_tlast;
	logic            s_axis_tvalid;
	logic            s_axis_tready;
	s2mm_pkg::addr_t m_axi_awaddr;
	s2mm_pkg::len_t  m_axi_awlen;
	logic            m_axi_awvalid;
	logic            m_axi_awready;
	s2mm_pkg::data_t m_axi_wdata;
	logic            m_axi_wlast;
	logic            m_axi_wvalid;
	logic            m_axi_wready;
	logic [1:0]      m_axi_bresp;
	logic            m_axi_bvalid;
	logic            m_axi_bready;
	s2mm_pkg::irq_t  irq;
	logic            err_en;
	s2mm_pkg::addr_t err_addr;
	logic [1:0]      stall;
	logic [31:0]     stall_seed;
	logic [31:0]     data_seed;

	s2mm_pkg::data_t beat_data [64];
	logic            beat_last [64];
	int              errors;
	int              errors_at_start;
	int              tests_passed;
	int              tests_failed;

	s2mm_top dut (.*);
	tb_axi_mem mem_model (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	assign stall = stall_seed[29:28]; // upper LCG bits
	always @(posedge clk) begin
		stall_seed <= lcg_next(stall_seed);
	end

	initial begin
		repeat (num_tests * cycles_per_test) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", num_tests * cycles_per_test);
		$display("FAIL: see errors above");
		$finish;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// expected outcome of one run from the beats sent
	function automatic expect_t predict(input int nbeats, input int size, input int err_burst,
			input logic [2:0] irq_en, input logic flush);
		expect_t e;
		int      nbytes;
		int      i;
		e      = '0;
		nbytes = nbeats * s2mm_pkg::beat_bytes;
		if (!flush) begin
			nbytes = nbytes - nbytes % s2mm_pkg::burst_bytes; // only full bursts start
		end
		if (nbytes > size) begin
			nbytes = size;
		end
		if (err_burst >= 0 && err_burst * s2mm_pkg::burst_bytes < nbytes) begin
			nbytes   = err_burst * s2mm_pkg::burst_bytes;
			e.flags  = 3'b010;
			e.irq[2] = irq_en[2];
		end else begin
			e.irq[0] = irq_en[0];
		end
		for (i = 0; i < nbytes / s2mm_pkg::beat_bytes; i++) begin
			if (beat_last[i]) begin
				e.msg_end = 32'((i + 1) * s2mm_pkg::beat_bytes);
				e.irq[1]  = irq_en[1];
			end
		end
		e.bytes     = 32'(nbytes);
		e.mem_beats = 16'(nbytes / s2mm_pkg::beat_bytes);
		// nothing pending, so the next run begins at once with cleared counters
		if (e.irq == '0) begin
			e.flags   = 3'b001;
			e.bytes   = '0;
			e.msg_end = '0;
		end
		return e;
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %0d ns %s: got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk); // access cycle
		rdata = prdata;
		err   = pslverr;
		check_val("pready", 64'(pready), 64'd1);
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic reg_readback(input logic [7:0] addr, input logic [31:0] wdata,
			input logic [31:0] exp, input string name);
		logic [31:0] rd;
		logic        err;
		apb_xfer(1'b1, addr, wdata, rd, err);
		apb_xfer(1'b0, addr, '0, rd, err);
		check_val(name, 64'(rd), 64'(exp));
		check_val({name, " pslverr"}, 64'(err), 64'd0);
	endtask

	task automatic setup_run(input logic [31:0] base, input logic [31:0] size,
			input logic [31:0] ctrl);
		logic [31:0] rd;
		logic        err;
		apb_xfer(1'b1, 8'h00, 32'h0, rd, err); // stop
		apb_xfer(1'b1, 8'h08, 32'h7, rd, err);
		apb_xfer(1'b1, 8'h0c, base, rd, err);
		apb_xfer(1'b1, 8'h10, size, rd, err);
		apb_xfer(1'b1, 8'h00, ctrl, rd, err);
	endtask

	task automatic make_beats(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			data_seed           = lcg_next(data_seed);
			beat_data[i][63:32] = data_seed;
			data_seed           = lcg_next(data_seed);
			beat_data[i][31:0]  = data_seed;
			beat_last[i]        = 1'b0;
		end
	endtask

	task automatic send_beats(input int n);
		int i;
		@(posedge clk);
		for (i = 0; i < n; i++) begin
			s_axis_tvalid <= 1'b1;
			s_axis_tdata  <= beat_data[i];
			s_axis_tlast  <= beat_last[i];
			@(negedge clk);
			while (!s_axis_tready) begin
				@(negedge clk);
			end
			@(posedge clk); // beat accepted here
		end
		s_axis_tvalid <= 1'b0;
	endtask

	task automatic wait_irq(input int idx);
		@(negedge clk);
		while (!irq[idx]) begin
			@(negedge clk);
		end
	endtask

	task automatic verify_run(input expect_t e, input logic [31:0] base);
		logic [31:0] rd;
		logic        err;
		int          i;
		@(negedge clk);
		check_val("irq", 64'(irq), 64'(e.irq));
		apb_xfer(1'b0, 8'h14, '0, rd, err);
		check_val("BYTES_WRITTEN", 64'(rd), 64'(e.bytes));
		apb_xfer(1'b0, 8'h18, '0, rd, err);
		check_val("LAST_MSG_END", 64'(rd), 64'(e.msg_end));
		apb_xfer(1'b0, 8'h08, '0, rd, err);
		check_val("IRQ", 64'(rd), 64'(e.irq));
		apb_xfer(1'b0, 8'h04, '0, rd, err);
		check_val("STATUS", 64'(rd), 64'(e.flags));
		for (i = 0; i < int'(e.mem_beats); i++) begin
			check_val($sformatf("mem[%h]", base + 32'(8 * i)),
				mem_model.mem[10'((base >> 3) + 32'(i))], beat_data[i]);
		end
		check_val("memory model protocol errors", 64'(mem_model.proto_errs), 64'd0);
	endtask

	task automatic end_test(input string name);
		if (errors == errors_at_start) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	//****************************************
	// test sequence
	//****************************************
	initial begin
		logic [31:0] rd;
		logic        err;
		int          b0;
		errors          = 0;
		errors_at_start = 0;
		tests_passed    = 0;
		tests_failed    = 0;
		stall_seed      = seed;
		data_seed       = seed;
		rst_n           = 1'b0;
		psel            = 1'b0;
		penable         = 1'b0;
		pwrite          = 1'b0;
		paddr           = '0;
		pwdata          = '0;
		s_axis_tdata    = '0;
		s_axis_tlast    = 1'b0;
		s_axis_tvalid   = 1'b0;
		err_en          = 1'b0;
		err_addr        = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		reg_readback(8'h0c, 32'h1234_5680, 32'h1234_5680, "MEM_BASE");
		reg_readback(8'h10, 32'h0000_0040, 32'h0000_0040, "MEM_SIZE");
		reg_readback(8'h00, 32'hffff_fff2, 32'h0000_0072, "CTRL"); // enable stays off
		reg_readback(8'h04, 32'hffff_ffff, 32'h0, "STATUS");
		reg_readback(8'h08, 32'hffff_ffff, 32'h0, "IRQ");
		reg_readback(8'h14, 32'hffff_ffff, 32'h0, "BYTES_WRITTEN");
		reg_readback(8'h18, 32'hffff_ffff, 32'h0, "LAST_MSG_END");
		apb_xfer(1'b0, 8'h20, '0, rd, err);
		check_val("pslverr on read of 0x20", 64'(err), 64'd1);
		apb_xfer(1'b1, 8'h1c, 32'h1, rd, err);
		check_val("pslverr on write of 0x1c", 64'(err), 64'd1);
		// configuration untouched by the writes above
		apb_xfer(1'b0, 8'h0c, '0, rd, err);
		check_val("MEM_BASE after read-only writes", 64'(rd), 64'h1234_5680);
		apb_xfer(1'b0, 8'h10, '0, rd, err);
		check_val("MEM_SIZE after read-only writes", 64'(rd), 64'h40);
		apb_xfer(1'b0, 8'h00, '0, rd, err);
		check_val("CTRL after read-only writes", 64'(rd), 64'h72);
		apb_xfer(1'b1, 8'h00, 32'h0, rd, err);
		end_test("register access");

		make_beats(64);
		setup_run(32'h0000, 32'd512, 32'h71);
		send_beats(64);
		wait_irq(0);
		verify_run(predict(64, 512, -1, 3'b111, 1'b0), 32'h0000);
		end_test("full fill");

		make_beats(64);
		beat_last[5]  = 1'b1;
		beat_last[37] = 1'b1;
		setup_run(32'h0400, 32'd512, 32'h71);
		send_beats(64);
		wait_irq(0);
		verify_run(predict(64, 512, -1, 3'b111, 1'b0), 32'h0400);
		end_test("message ends");

		make_beats(5);
		setup_run(32'h0800, 32'd512, 32'h71);
		b0 = mem_model.bursts;
		send_beats(5);
		repeat (4) @(posedge clk);
		apb_xfer(1'b1, 8'h00, 32'h73, rd, err); // flush the five waiting beats
		wait_irq(0);
		verify_run(predict(5, 512, -1, 3'b111, 1'b1), 32'h0800);
		check_val("burst count", 64'(mem_model.bursts - b0), 64'd1);
		check_val("m_axi_awlen", 64'(mem_model.last_len), 64'd4);
		apb_xfer(1'b0, 8'h00, '0, rd, err);
		check_val("CTRL flush bit", 64'(rd[1]), 64'd0);
		end_test("flush");

		make_beats(32);
		err_addr <= 32'h0c80; // second burst of the run
		err_en   <= 1'b1;
		setup_run(32'h0c00, 32'd512, 32'h71);
		send_beats(32);
		wait_irq(2);
		verify_run(predict(32, 512, 1, 3'b111, 1'b0), 32'h0c00);
		repeat (20) @(posedge clk);
		apb_xfer(1'b0, 8'h04, '0, rd, err);
		check_val("STATUS while error pending", 64'(rd), 64'h2);
		err_en <= 1'b0;
		apb_xfer(1'b1, 8'h08, 32'h7, rd, err);
		repeat (4) @(posedge clk);
		apb_xfer(1'b0, 8'h04, '0, rd, err);
		check_val("STATUS after IRQ clear", 64'(rd), 64'h1);
		end_test("error response");

		make_beats(16);
		setup_run(32'h1000, 32'd128, 32'h01);
		b0 = mem_model.bursts;
		send_beats(16);
		while (mem_model.bursts == b0) begin
			@(negedge clk);
		end
		repeat (4) @(posedge clk);
		verify_run(predict(16, 128, -1, 3'b000, 1'b0), 32'h1000);
		end_test("interrupt masking");

		$display("%0d of %0d tests passed, %0d failed, %0d check errors",
			tests_passed, num_tests, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
